//--- include/vec_lsu_defs.svh
////////////////////////////////////////////////////////////
// Vector LSU widths
// Scalar, vector register and memory bus sizes
////////////////////////////////////////////////////////////
`ifndef VEC_LSU_DEFS_SVH
`define VEC_LSU_DEFS_SVH

// Scalar side
`define XLEN      32            // Address and scalar width

// Vector side
`define VLEN      128           // One vector register

// Bus side
`define BEAT_BITS 64            // One bus beat
`define BEAT_SIZE 3             // log2 of bytes per beat
`define BUS_BITS  `VLEN         // A whole burst travels at once
`define STRB_BITS (`VLEN / 8)   // One strobe per byte lane

`endif

//--- rtl/lsu_vec_pkg.sv
////////////////////////////////////////////////////////////
// Vector side types of the LSU
// Element width code, element count and access kind
////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_lsu_defs.svh"

package lsu_vec_pkg;

    // 0=8, 1=16, 2=32, 3=64 bits
    typedef logic [1:0] sew_code_t;

    // Holds 0 up to VLEN/8
    typedef logic [$clog2(`VLEN / 8):0] elem_cnt_t;

    typedef logic [`VLEN-1:0] vreg_t;    // One vector register

    // How element addresses are formed
    typedef enum logic [1:0] {
        UNIT,    // One burst over contiguous memory
        CONST,   // Base plus i times stride
        INDEX    // Base plus offset from vs2
    } access_kind_t;

endpackage

`default_nettype wire

//--- rtl/lsu_mem_pkg.sv
////////////////////////////////////////////////////////////
// Memory side types of the LSU
// Address, strobe, burst fields and controller states
////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_lsu_defs.svh"

package lsu_mem_pkg;

    typedef logic [`XLEN-1:0]      addr_t;
    typedef logic [`STRB_BITS-1:0] strb_t;
    typedef logic [7:0]            burst_len_t;   // Beats minus one
    typedef logic [2:0]            burst_size_t;  // log2 of bytes per beat
    typedef logic [1:0]            burst_type_t;

    localparam burst_type_t BURST_INCR = 2'b01;

    typedef enum logic [3:0] {
        IDLE, LOAD_UNIT, LOAD_ELEM, STORE_UNIT, STORE_ELEM, WAIT_DONE
    } lsu_state_e;

endpackage

`default_nettype wire

//--- rtl/lsu_decode.sv
////////////////////////////////////////////////////////////
// LSU decode
// Picks the access kind and maps the index width field
////////////////////////////////////////////////////////////
`default_nettype none

module lsu_decode (
    input  wire lsu_mem_pkg::addr_t     rs2_data,    // Stride in bytes
    input  wire                         stride_sel,
    input  wire                         index_str,
    input  wire lsu_vec_pkg::sew_code_t sew,
    input  wire [2:0]                   width,       // RISC-V width field
    output lsu_vec_pkg::access_kind_t   kind,
    output lsu_vec_pkg::sew_code_t      idx_code,
    output logic                        error_flag
);
    logic bad_width;
    logic unit_hit;

    // Width field to index width code
    always_comb begin
        bad_width = 1'b0;
        case (width)
            3'b000:  idx_code = 2'd0;
            3'b101:  idx_code = 2'd1;
            3'b110:  idx_code = 2'd2;
            3'b111: begin
                idx_code  = 2'd3;
                bad_width = 1'b1;            // 64-bit offsets unsupported
            end
            default: begin
                idx_code  = 2'd0;
                bad_width = 1'b1;
            end
        endcase
    end

    // Stride equal to element size is contiguous
    assign unit_hit = stride_sel || (rs2_data == (lsu_mem_pkg::addr_t'(1) << sew));

    always_comb begin
        if (index_str)     kind = lsu_vec_pkg::INDEX;   // Index wins
        else if (unit_hit) kind = lsu_vec_pkg::UNIT;
        else               kind = lsu_vec_pkg::CONST;
    end

    assign error_flag = index_str && bad_width;

endmodule

`default_nettype wire

//--- rtl/lsu_ctrl.sv
////////////////////////////////////////////////////////////
// LSU controller
// Issues one burst or vl element requests, one at a time,
// and pulses completion after the last answer
////////////////////////////////////////////////////////////
`default_nettype none

module lsu_ctrl (
    input  wire                            clk,
    input  wire                            n_rst,
    input  wire                            ld_inst,
    input  wire                            st_inst,
    input  wire                            inst_done,
    input  wire lsu_vec_pkg::access_kind_t kind,
    input  wire                            error_flag,
    input  wire lsu_vec_pkg::elem_cnt_t    vl,
    input  wire                            burst_valid_data,
    input  wire                            burst_wr_valid,
    output logic                           ld_req,
    output logic                           st_req,
    output logic                           issue,          // Registers request fields
    output logic                           start,          // New instruction accepted
    output lsu_vec_pkg::elem_cnt_t         elem_idx,       // Requests issued so far
    output logic                           load_capture,
    output logic                           is_loaded,
    output logic                           is_stored
);
    lsu_mem_pkg::lsu_state_e state, state_nxt;
    logic loading;       // Current or starting access is a load
    logic answer;        // Memory reply for the outstanding request
    logic last;          // No more requests after this reply

    assign start   = (state == lsu_mem_pkg::IDLE) && (ld_inst || st_inst) && !error_flag;
    assign loading = (state == lsu_mem_pkg::IDLE) ? ld_inst :
                     (state == lsu_mem_pkg::LOAD_UNIT) || (state == lsu_mem_pkg::LOAD_ELEM);

    always_comb begin
        answer = 1'b0;
        if (state != lsu_mem_pkg::IDLE && state != lsu_mem_pkg::WAIT_DONE)
            answer = loading ? burst_valid_data : burst_wr_valid;
    end

    // Unit access is a single burst
    assign last = (state == lsu_mem_pkg::LOAD_UNIT) || (state == lsu_mem_pkg::STORE_UNIT) ||
                  (elem_idx == vl);

    assign issue        = start || (answer && !last);
    assign load_capture = answer && loading;

    always_comb begin
        state_nxt = state;
        case (state)
            lsu_mem_pkg::IDLE: begin
                if (start) begin
                    if (ld_inst)
                        state_nxt = (kind == lsu_vec_pkg::UNIT) ? lsu_mem_pkg::LOAD_UNIT
                                                                : lsu_mem_pkg::LOAD_ELEM;
                    else
                        state_nxt = (kind == lsu_vec_pkg::UNIT) ? lsu_mem_pkg::STORE_UNIT
                                                                : lsu_mem_pkg::STORE_ELEM;
                end
            end
            lsu_mem_pkg::WAIT_DONE: if (inst_done) state_nxt = lsu_mem_pkg::IDLE;
            default: if (answer && last) state_nxt = lsu_mem_pkg::WAIT_DONE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state     <= lsu_mem_pkg::IDLE;
            elem_idx  <= '0;
            ld_req    <= 1'b0;
            st_req    <= 1'b0;
            is_loaded <= 1'b0;
            is_stored <= 1'b0;
        end else begin
            state     <= state_nxt;
            ld_req    <= issue && loading;       // Request follows its issue by one cycle
            st_req    <= issue && !loading;
            is_loaded <= answer && last && loading;
            is_stored <= answer && last && !loading;
            if (state == lsu_mem_pkg::WAIT_DONE)
                elem_idx <= '0;                  // Ready for the next instruction
            else if (issue)
                elem_idx <= elem_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_addr_gen.sv
////////////////////////////////////////////////////////////
// LSU address generator
// Registers address and burst fields on each issue
////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_lsu_defs.svh"

module lsu_addr_gen (
    input  wire                            clk,
    input  wire                            n_rst,
    input  wire                            issue,
    input  wire lsu_vec_pkg::access_kind_t kind,
    input  wire lsu_vec_pkg::sew_code_t    sew,
    input  wire lsu_vec_pkg::sew_code_t    idx_code,
    input  wire lsu_vec_pkg::elem_cnt_t    elem_idx,
    input  wire lsu_mem_pkg::addr_t        rs1_data,
    input  wire lsu_mem_pkg::addr_t        rs2_data,
    input  wire lsu_vec_pkg::vreg_t        vs2_data,
    input  wire lsu_vec_pkg::elem_cnt_t    vl,
    output lsu_mem_pkg::addr_t             lsu2mem_addr,
    output lsu_mem_pkg::burst_len_t        burst_len,
    output lsu_mem_pkg::burst_size_t       burst_size,
    output lsu_mem_pkg::burst_type_t       burst_type
);
    logic [9:0]          idx_shift;    // Bit position of index element
    lsu_vec_pkg::vreg_t  idx_word;
    lsu_mem_pkg::addr_t  idx_off;
    logic [11:0]         total_bits;   // Unit access size
    logic [11:0]         beats;

    always_comb begin
        idx_shift = 10'(elem_idx) << ({1'b0, idx_code} + 3'd3);
        idx_word  = vs2_data >> idx_shift;
        case (idx_code)                // Offsets are zero-extended
            2'd0:    idx_off = lsu_mem_pkg::addr_t'(idx_word[7:0]);
            2'd1:    idx_off = lsu_mem_pkg::addr_t'(idx_word[15:0]);
            default: idx_off = idx_word[`XLEN-1:0];
        endcase
        total_bits = 12'(vl) << ({1'b0, sew} + 3'd3);
        beats      = (total_bits + `BEAT_BITS - 1) / `BEAT_BITS;   // Round up
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            lsu2mem_addr <= '0;
            burst_len    <= '0;
            burst_size   <= '0;
            burst_type   <= '0;
        end else if (issue) begin
            burst_type <= lsu_mem_pkg::BURST_INCR;
            case (kind)
                lsu_vec_pkg::UNIT: begin
                    lsu2mem_addr <= rs1_data;
                    burst_len    <= lsu_mem_pkg::burst_len_t'(beats - 1'b1);
                    burst_size   <= `BEAT_SIZE;
                end
                default: begin                  // One element per request
                    lsu2mem_addr <= (kind == lsu_vec_pkg::INDEX) ? rs1_data + idx_off
                                  : rs1_data + lsu_mem_pkg::addr_t'(elem_idx) * rs2_data;
                    burst_len    <= '0;
                    burst_size   <= {1'b0, sew};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_load_pack.sv
////////////////////////////////////////////////////////////
// LSU load packer
// Builds vd from one masked burst or one element per reply
////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_lsu_defs.svh"

module lsu_load_pack (
    input  wire                            clk,
    input  wire                            n_rst,
    input  wire                            start,
    input  wire                            load_capture,
    input  wire lsu_vec_pkg::access_kind_t kind,
    input  wire lsu_vec_pkg::sew_code_t    sew,
    input  wire lsu_vec_pkg::elem_cnt_t    vl,
    input  wire lsu_vec_pkg::elem_cnt_t    elem_idx,
    input  wire [`BUS_BITS-1:0]            mem2lsu_data,
    output lsu_vec_pkg::vreg_t             vd_data
);
    logic [7:0]         base;      // First byte written
    logic [7:0]         n_bytes;   // Bytes written
    lsu_vec_pkg::vreg_t ins;       // Reply moved to its byte position

    always_comb begin
        if (kind == lsu_vec_pkg::UNIT) begin
            base    = '0;
            n_bytes = 8'(vl) << sew;
        end else begin
            // elem_idx already counts the request being answered
            base    = 8'(elem_idx - 1'b1) << sew;
            n_bytes = 8'd1 << sew;
        end
        ins = mem2lsu_data << {base, 3'b000};
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vd_data <= '0;
        end else if (start) begin
            vd_data <= '0;                  // Tail beyond vl stays zero
        end else if (load_capture) begin
            for (int b = 0; b < `STRB_BITS; b++) begin
                if (b >= base && b < base + n_bytes)
                    vd_data[8*b +: 8] <= ins[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/lsu_store_pack.sv
////////////////////////////////////////////////////////////
// LSU store packer
// Registers store data and byte strobes for each request
////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_lsu_defs.svh"

module lsu_store_pack (
    input  wire                            clk,
    input  wire                            n_rst,
    input  wire                            issue,
    input  wire lsu_vec_pkg::access_kind_t kind,
    input  wire lsu_vec_pkg::sew_code_t    sew,
    input  wire lsu_vec_pkg::elem_cnt_t    vl,
    input  wire lsu_vec_pkg::elem_cnt_t    elem_idx,
    input  wire lsu_vec_pkg::vreg_t        vs3_data,
    output lsu_vec_pkg::vreg_t             lsu2mem_data,
    output lsu_mem_pkg::strb_t             wr_strobe
);
    logic                   unit;
    logic [7:0]             n_bytes;
    lsu_vec_pkg::vreg_t     shifted;     // Element i in the low lanes
    lsu_vec_pkg::vreg_t     data_nxt;
    lsu_mem_pkg::strb_t     strb_nxt;

    always_comb begin
        unit    = (kind == lsu_vec_pkg::UNIT);
        n_bytes = unit ? (8'(vl) << sew) : (8'd1 << sew);
        shifted = unit ? vs3_data : vs3_data >> (10'(elem_idx) << ({1'b0, sew} + 3'd3));
        for (int b = 0; b < `STRB_BITS; b++) begin
            strb_nxt[b] = (b < n_bytes);
            // Whole register on a burst, clean upper lanes on an element
            data_nxt[8*b +: 8] = (unit || strb_nxt[b]) ? shifted[8*b +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            lsu2mem_data <= '0;
            wr_strobe    <= '0;
        end else if (issue) begin
            lsu2mem_data <= data_nxt;
            wr_strobe    <= strb_nxt;
        end
    end

endmodule

`default_nettype wire

//--- rtl/vec_lsu.sv
////////////////////////////////////////////////////////////
// Vector load/store unit top
// Decode, execute and result stages wired together
////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_lsu_defs.svh"

module vec_lsu (
    input  wire                         clk,
    input  wire                         n_rst,
    input  wire lsu_mem_pkg::addr_t     rs1_data,      // Base address
    input  wire lsu_mem_pkg::addr_t     rs2_data,      // Stride in bytes
    input  wire lsu_vec_pkg::elem_cnt_t vl,
    input  wire lsu_vec_pkg::sew_code_t sew,
    input  wire [2:0]                   width,         // Index width field
    input  wire                         stride_sel,
    input  wire                         ld_inst,
    input  wire                         st_inst,
    input  wire                         index_str,
    input  wire lsu_vec_pkg::vreg_t     vs2_data,      // Index offsets
    input  wire lsu_vec_pkg::vreg_t     vs3_data,      // Store data
    input  wire                         inst_done,
    input  wire [`BUS_BITS-1:0]         mem2lsu_data,
    input  wire                         burst_valid_data,
    input  wire                         burst_wr_valid,
    output lsu_mem_pkg::addr_t          lsu2mem_addr,
    output lsu_vec_pkg::vreg_t          lsu2mem_data,
    output lsu_mem_pkg::strb_t          wr_strobe,
    output logic                        ld_req,
    output logic                        st_req,
    output lsu_mem_pkg::burst_len_t     burst_len,
    output lsu_mem_pkg::burst_size_t    burst_size,
    output lsu_mem_pkg::burst_type_t    burst_type,
    output lsu_vec_pkg::vreg_t          vd_data,
    output logic                        is_loaded,
    output logic                        is_stored,
    output logic                        error_flag
);
    lsu_vec_pkg::access_kind_t kind;
    lsu_vec_pkg::sew_code_t    idx_code;
    lsu_vec_pkg::elem_cnt_t    elem_idx;
    logic                      issue, start, load_capture;

    lsu_decode u_decode (
        .rs2_data(rs2_data), .stride_sel(stride_sel), .index_str(index_str), .sew(sew),
        .width(width), .kind(kind), .idx_code(idx_code), .error_flag(error_flag)
    );

    lsu_ctrl u_ctrl (
        .clk(clk), .n_rst(n_rst), .ld_inst(ld_inst), .st_inst(st_inst),
        .inst_done(inst_done), .kind(kind), .error_flag(error_flag), .vl(vl),
        .burst_valid_data(burst_valid_data), .burst_wr_valid(burst_wr_valid),
        .ld_req(ld_req), .st_req(st_req), .issue(issue), .start(start),
        .elem_idx(elem_idx), .load_capture(load_capture),
        .is_loaded(is_loaded), .is_stored(is_stored)
    );

    lsu_addr_gen u_addr_gen (
        .clk(clk), .n_rst(n_rst), .issue(issue), .kind(kind), .sew(sew),
        .idx_code(idx_code), .elem_idx(elem_idx), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .vs2_data(vs2_data), .vl(vl), .lsu2mem_addr(lsu2mem_addr),
        .burst_len(burst_len), .burst_size(burst_size), .burst_type(burst_type)
    );

    lsu_load_pack u_load_pack (
        .clk(clk), .n_rst(n_rst), .start(start), .load_capture(load_capture),
        .kind(kind), .sew(sew), .vl(vl), .elem_idx(elem_idx),
        .mem2lsu_data(mem2lsu_data), .vd_data(vd_data)
    );

    lsu_store_pack u_store_pack (
        .clk(clk), .n_rst(n_rst), .issue(issue), .kind(kind), .sew(sew), .vl(vl),
        .elem_idx(elem_idx), .vs3_data(vs3_data),
        .lsu2mem_data(lsu2mem_data), .wr_strobe(wr_strobe)
    );

endmodule

`default_nettype wire

//--- testbench/tb_lsu_mem.sv
////////////////////////////////////////////////////////////
// Memory responder for the vector LSU testbench
// Byte array answering each request after a random delay
////////////////////////////////////////////////////////////
`default_nettype none

module tb_lsu_mem (
    input  wire         clk,
    input  wire         n_rst,
    input  wire         ld_req,
    input  wire         st_req,
    input  wire [31:0]  addr,
    input  wire [127:0] wdata,
    input  wire [15:0]  strobe,
    input  wire [2:0]   burst_size,
    output logic [127:0] rdata,
    output logic        rd_valid,
    output logic        wr_valid
);
    logic [7:0] mem [0:1023];    // Filled by the testbench top

    initial begin
        rdata    = '0;
        rd_valid = 1'b0;
        wr_valid = 1'b0;
    end

    // Requests are sampled on the falling edge, answers driven there too
    always begin : respond
        int unsigned delay;
        int          n_bytes;
        logic        is_ld;
        if (n_rst === 1'b1 && (ld_req || st_req)) begin
            is_ld   = ld_req;
            delay   = $urandom_range(1, 6);
            n_bytes = (burst_size == 3'd3) ? 16 : (1 << burst_size);   // Burst fills the port
            if (is_ld) begin
                rdata = '0;
                for (int b = 0; b < n_bytes; b++)
                    rdata[8*b +: 8] = mem[(addr + b) % 1024];
            end else begin
                for (int b = 0; b < 16; b++)
                    if (strobe[b]) mem[(addr + b) % 1024] = wdata[8*b +: 8];
            end
            repeat (delay) @(negedge clk);
            rd_valid = is_ld;
            wr_valid = !is_ld;
            @(negedge clk);
            rd_valid = 1'b0;
            wr_valid = 1'b0;
        end else begin
            @(negedge clk);
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_vec_lsu.sv
////////////////////////////////////////////////////////////
// Vector LSU testbench
// Runs unit, strided, indexed and error cases against a
// memory model, checking with assertions
////////////////////////////////////////////////////////////
`default_nettype none

module tb_vec_lsu;
    localparam int PERIOD    = 8;
    localparam int LIMIT     = (16 + 6 * 16 * (6 + 4)) * PERIOD;   // Reset plus worst case tests

    logic clk, n_rst;
    logic [31:0] rs1_data, rs2_data, lsu2mem_addr;
    logic [4:0] vl;
    logic [1:0] sew, burst_type;
    logic [2:0] width, burst_size;
    logic stride_sel, ld_inst, st_inst, index_str, inst_done;
    logic [127:0] vs2_data, vs3_data, mem2lsu_data, lsu2mem_data, vd_data;
    logic burst_valid_data, burst_wr_valid, ld_req, st_req, is_loaded, is_stored, error_flag;
    logic [15:0] wr_strobe;
    logic [7:0] burst_len;
    int errors = 0;
    int tests  = 0;
    logic [31:0]  req_addr[$];    // Request log, one entry per pulse
    logic [127:0] req_data[$];
    logic [15:0]  req_strb[$];
    logic [7:0]   req_len[$];
    logic [2:0]   req_size[$];
    logic [127:0] vd_done;        // vd_data seen with the completion pulse

    vec_lsu vec_lsu_inst (.*);

    tb_lsu_mem mem_model (
        .clk(clk), .n_rst(n_rst), .ld_req(ld_req), .st_req(st_req), .addr(lsu2mem_addr),
        .wdata(lsu2mem_data), .strobe(wr_strobe), .burst_size(burst_size),
        .rdata(mem2lsu_data), .rd_valid(burst_valid_data), .wr_valid(burst_wr_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT);
        $display("Watchdog expired after %0d time units", LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Log every request pulse
    always @(negedge clk) begin
        if (ld_req || st_req) begin
            req_addr.push_back(lsu2mem_addr);
            req_data.push_back(lsu2mem_data);
            req_strb.push_back(wr_strobe);
            req_len.push_back(burst_len);
            req_size.push_back(burst_size);
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!n_rst) !(ld_req && st_req))
        else begin
            errors++;
            $display("Load and store requests raised together");
        end
    a_start: assert property (@(posedge clk) disable iff (!n_rst)
        (ld_inst || st_inst) && !error_flag |=> (ld_req || st_req))
        else begin
            errors++;
            $display("No request one cycle after instruction start");
        end
    a_err: assert property (@(posedge clk) disable iff (!n_rst)
        error_flag && (ld_inst || st_inst) |=> !(ld_req || st_req))
        else begin
            errors++;
            $display("Request issued under a configuration error");
        end
    a_type: assert property (@(posedge clk) disable iff (!n_rst)
        (ld_req || st_req) |-> burst_type == 2'b01)
        else begin
            errors++;
            $display("Burst type is not INCR on a request");
        end
    a_answer: assert property (@(posedge clk) disable iff (!n_rst)
        (burst_valid_data || burst_wr_valid) |=> (ld_req || st_req || is_loaded || is_stored))
        else begin
            errors++;
            $display("No request or completion one cycle after a memory answer");
        end
    a_pulse: assert property (@(posedge clk) disable iff (!n_rst)
        (is_loaded || is_stored) |=> !(is_loaded || is_stored))
        else begin
            errors++;
            $display("Completion pulse longer than one cycle");
        end

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        assert (exp === act)
        else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // Pulses the instruction, waits for completion, then retires it
    task automatic run_inst(input logic ld);
        req_addr.delete();
        req_data.delete();
        req_strb.delete();
        req_len.delete();
        req_size.delete();
        ld_inst = ld;
        st_inst = !ld;
        @(negedge clk);
        ld_inst = 1'b0;
        st_inst = 1'b0;
        while (!(is_loaded || is_stored)) @(negedge clk);
        vd_done = vd_data;
        inst_done = 1'b1;
        @(negedge clk);
        inst_done = 1'b0;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        $display("test %s: %0d errors", name, errors - err0);
    endtask

    initial begin
        int err0, stride, off;
        logic [127:0] exp;
        logic [31:0] a;
        logic [7:0] snap [0:31];
        void'($urandom(79940));
        {rs1_data, rs2_data, vl, sew, width} = '0;
        {stride_sel, ld_inst, st_inst, index_str, inst_done} = '0;
        {vs2_data, vs3_data} = '0;
        n_rst = 1'b0;
        for (int i = 0; i < 1024; i++) mem_model.mem[i] = 8'($urandom);
        repeat (16) @(negedge clk);
        n_rst = 1'b1;

        err0 = errors;                                   // Reset and idle
        repeat (4) begin
            @(negedge clk);
            check("reset outputs", 4'b0000, {ld_req, st_req, is_loaded, is_stored});
        end
        check("reset vd", '0, vd_data);
        finish_test("reset_idle", err0);

        err0 = errors;                                   // Unit load of 32-bit elements
        sew = 2'd2;
        stride_sel = 1'b1;
        vl = 5'($urandom_range(1, 4));
        rs1_data = $urandom_range(0, 900);
        run_inst(1'b1);
        check("unit_load count", 1, req_addr.size());
        check("unit_load addr", rs1_data, req_addr[0]);
        check("unit_load size", 3, req_size[0]);
        check("unit_load len", (vl * 32 + 63) / 64 - 1, req_len[0]);
        for (int b = 0; b < 16; b++)
            exp[8*b +: 8] = (b < vl * 4) ? mem_model.mem[(rs1_data + b) % 1024] : 8'h00;
        check("unit_load vd", exp, vd_done);
        finish_test("unit_load", err0);

        err0 = errors;                                   // Strided load of 16-bit elements
        sew = 2'd1;
        stride_sel = 1'b0;
        vl = 5'($urandom_range(2, 8));
        stride = $urandom_range(3, 20);
        rs2_data = stride;
        rs1_data = $urandom_range(0, 500);
        run_inst(1'b1);
        check("const_load count", vl, req_addr.size());
        exp = '0;
        for (int i = 0; i < vl; i++) begin
            a = rs1_data + i * stride;
            check("const_load addr", a, req_addr[i]);
            check("const_load len size", {8'd0, 3'd1}, {req_len[i], req_size[i]});
            exp[16*i +: 16] = {mem_model.mem[(a + 1) % 1024], mem_model.mem[a % 1024]};
        end
        check("const_load vd", exp, vd_done);
        finish_test("const_load", err0);

        err0 = errors;                                   // Indexed store with 16-bit offsets
        sew = 2'd2;
        index_str = 1'b1;
        width = 3'b101;
        vl = 5'd4;
        rs1_data = $urandom_range(0, 500);
        vs3_data = {$urandom, $urandom, $urandom, $urandom};
        vs2_data = {$urandom, $urandom, $urandom, $urandom};
        for (int i = 0; i < 4; i++) vs2_data[16*i +: 16] = 16'(i * 16 + $urandom_range(0, 3) * 4);
        run_inst(1'b0);
        check("index_store count", 4, req_addr.size());
        for (int i = 0; i < 4; i++) begin
            off = vs2_data[16*i +: 16];
            check("index_store addr", rs1_data + off, req_addr[i]);
            check("index_store strobe", 16'h000F, req_strb[i]);
            check("index_store data", {96'd0, vs3_data[32*i +: 32]}, req_data[i]);
            for (int b = 0; b < 4; b++)
                check("index_store mem", vs3_data[32*i + 8*b +: 8],
                      mem_model.mem[(rs1_data + off + b) % 1024]);
        end
        index_str = 1'b0;
        width = 3'b000;
        finish_test("index_store", err0);

        err0 = errors;                                   // Unit store of byte elements
        sew = 2'd0;
        stride_sel = 1'b1;
        vl = 5'($urandom_range(1, 16));
        rs1_data = $urandom_range(600, 700);
        vs3_data = {$urandom, $urandom, $urandom, $urandom};
        for (int k = 0; k < 32; k++) snap[k] = mem_model.mem[rs1_data - 8 + k];
        run_inst(1'b0);
        check("unit_store count", 1, req_addr.size());
        check("unit_store strobe", 16'((32'd1 << vl) - 1), req_strb[0]);
        for (int k = 0; k < 32; k++)
            check("unit_store mem", (k >= 8 && k - 8 < vl) ? vs3_data[8*(k-8) +: 8] : snap[k],
                  mem_model.mem[rs1_data - 8 + k]);
        finish_test("unit_store", err0);

        err0 = errors;                                   // 64-bit index width is rejected
        index_str = 1'b1;
        width = 3'b111;
        req_addr.delete();
        @(negedge clk);
        ld_inst = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check("error flag", 1, error_flag);
        end
        check("error requests", 0, req_addr.size());
        ld_inst = 1'b0;
        index_str = 1'b0;
        width = 3'b000;
        finish_test("error_check", err0);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
rtl/lsu_vec_pkg.sv
rtl/lsu_mem_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_ctrl.sv
rtl/lsu_addr_gen.sv
rtl/lsu_load_pack.sv
rtl/lsu_store_pack.sv
rtl/vec_lsu.sv
testbench/tb_lsu_mem.sv
testbench/tb_vec_lsu.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the vector LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_vec_lsu \
    -Mdir obj_dir -o tb_sim > build.log 2>&1 || { echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
